// File: source/cpu_pkg.sv
package cpu_pkg;

    ////////////////////
    // Widths

    localparam int word_size     = 16;
    localparam int reg_count     = 4;
    localparam int reg_addr_size = 2;
    localparam int imm_size      = 8;
    localparam int target_size   = 12;

    // JAL writes its return address here
    localparam int link_reg = 2;

    ////////////////////
    // Instruction fields

    localparam int op_msb     = 15;
    localparam int op_lsb     = 12;
    localparam int rs_msb     = 11;
    localparam int rs_lsb     = 10;
    localparam int rt_msb     = 9;
    localparam int rt_lsb     = 8;
    localparam int rd_msb     = 7;
    localparam int rd_lsb     = 6;
    localparam int func_msb   = 5;
    localparam int func_lsb   = 0;
    localparam int imm_msb    = 7;
    localparam int imm_lsb    = 0;
    localparam int target_msb = 11;
    localparam int target_lsb = 0;

    ////////////////////
    // Opcodes

    localparam logic [3:0] op_bne   = 4'd0;
    localparam logic [3:0] op_beq   = 4'd1;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_lhi   = 4'd6;
    localparam logic [3:0] op_lwd   = 4'd7;
    localparam logic [3:0] op_swd   = 4'd8;
    localparam logic [3:0] op_jmp   = 4'd9;
    localparam logic [3:0] op_jal   = 4'd10;
    localparam logic [3:0] op_rtype = 4'd15;

    // Function codes under op_rtype
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    // Register write source
    localparam logic [1:0] wr_sel_alu  = 2'd0;
    localparam logic [1:0] wr_sel_mem  = 2'd1;
    localparam logic [1:0] wr_sel_link = 2'd2;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } cpu_state_t;

endpackage

// File: source/cpu_ctrl_if.sv
`timescale 1ns/1ns

interface cpu_ctrl_if import cpu_pkg::*; ();

    logic                     pc_inc;
    logic                     pc_load_branch;
    logic                     pc_load_jump;
    logic [word_size-1:0]     imm_ext;
    logic [target_size-1:0]   jump_target;
    logic [reg_addr_size-1:0] rs_addr;
    logic [reg_addr_size-1:0] rt_addr;
    logic [reg_addr_size-1:0] wr_addr;
    logic                     reg_write;
    logic [1:0]               wr_sel;
    alu_op_t                  alu_op;
    logic                     alu_src_imm;
    logic                     retire;

    modport ctrl (
        output pc_inc, pc_load_branch, pc_load_jump, imm_ext, jump_target,
        output rs_addr, rt_addr, wr_addr, reg_write, wr_sel,
        output alu_op, alu_src_imm, retire
    );

    modport pc (
        input pc_inc, pc_load_branch, pc_load_jump, imm_ext, jump_target, retire
    );

    modport regs (
        input rs_addr, rt_addr, wr_addr, reg_write
    );

    modport alu (
        input alu_op, alu_src_imm, imm_ext
    );

endinterface

// File: source/cpu_control.sv
`timescale 1ns/1ns

module cpu_control
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    cpu_ctrl_if.ctrl             ctrl,
    input  logic [word_size-1:0] rs_data,
    input  logic                 zero,
    input  logic [word_size-1:0] read_data,
    input  logic                 mem_ready,
    output logic                 read_m,
    output logic                 write_m,
    output logic                 use_alu_addr,
    output logic                 output_valid,
    output logic                 is_halted
);

    logic [word_size-1:0] ir;
    cpu_state_t           state;
    cpu_state_t           next_state;

    logic [3:0] opcode;
    logic [5:0] func;
    logic       is_rtype;
    logic       is_arith;
    logic       is_wwd;
    logic       is_hlt;
    logic       is_lwd;
    logic       is_swd;
    logic       is_jump;
    logic       taken;
    logic       writes_reg;

    ////////////////////
    // Decode

    assign opcode   = ir[op_msb:op_lsb];
    assign func     = ir[func_msb:func_lsb];
    assign is_rtype = (opcode == op_rtype);
    assign is_arith = is_rtype && (func == fn_add || func == fn_sub ||
                                   func == fn_and || func == fn_orr);
    assign is_wwd   = is_rtype && (func == fn_wwd);
    assign is_hlt   = is_rtype && (func == fn_hlt);
    assign is_lwd   = (opcode == op_lwd);
    assign is_swd   = (opcode == op_swd);
    assign is_jump  = (opcode == op_jmp) || (opcode == op_jal);
    assign taken    = ((opcode == op_beq) && zero) || ((opcode == op_bne) && !zero);

    assign writes_reg = is_arith || is_lwd || opcode == op_adi ||
                        opcode == op_lhi || opcode == op_jal;

    assign ctrl.rs_addr     = ir[rs_msb:rs_lsb];
    assign ctrl.rt_addr     = ir[rt_msb:rt_lsb];
    assign ctrl.imm_ext     = {{(word_size - imm_size){ir[imm_msb]}}, ir[imm_msb:imm_lsb]};
    assign ctrl.jump_target = ir[target_msb:target_lsb];
    assign ctrl.alu_src_imm = (opcode == op_adi) || (opcode == op_lhi) || is_lwd || is_swd;

    always_comb begin
        ctrl.alu_op = alu_add;
        if (is_rtype) begin
            case (func)
                fn_sub:  ctrl.alu_op = alu_sub;
                fn_and:  ctrl.alu_op = alu_and;
                fn_orr:  ctrl.alu_op = alu_or;
                default: ctrl.alu_op = alu_add;
            endcase
        end else if (opcode == op_lhi) begin
            ctrl.alu_op = alu_pass_b;
        end
    end

    always_comb begin
        if (opcode == op_jal) begin
            ctrl.wr_addr = reg_addr_size'(link_reg);
            ctrl.wr_sel  = wr_sel_link;
        end else if (is_rtype) begin
            ctrl.wr_addr = ir[rd_msb:rd_lsb];
            ctrl.wr_sel  = wr_sel_alu;
        end else begin
            ctrl.wr_addr = ir[rt_msb:rt_lsb];
            ctrl.wr_sel  = is_lwd ? wr_sel_mem : wr_sel_alu;
        end
    end

    ////////////////////
    // State machine

    always_comb begin
        next_state = state;
        case (state)
            st_fetch:     if (read_m && mem_ready) next_state = st_decode;
            st_decode:    next_state = st_execute;
            st_execute:   next_state = (is_lwd || is_swd) ? st_memory : st_writeback;
            st_memory:    if ((read_m || write_m) && mem_ready) next_state = st_writeback;
            st_writeback: next_state = is_hlt ? st_halted : st_fetch;
            default:      next_state = st_halted;
        endcase
    end

    // Strobes are registered so they rise the cycle after reset
    always_ff @(posedge clk) begin
        if (reset_n) begin
            state   <= st_fetch;
            read_m  <= 1'b0;
            write_m <= 1'b0;
        end else begin
            state   <= next_state;
            read_m  <= (next_state == st_fetch) || (next_state == st_memory && is_lwd);
            write_m <= (next_state == st_memory) && is_swd;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && read_m && mem_ready) begin
            ir <= read_data;
        end
    end

    assign use_alu_addr        = (state == st_memory);
    assign ctrl.pc_load_branch = (state == st_execute) && taken;
    assign ctrl.pc_load_jump   = (state == st_execute) && is_jump;
    // PC already moved in execute for taken branches and jumps
    assign ctrl.pc_inc         = (state == st_writeback) && !(is_jump || taken);
    assign ctrl.reg_write      = (state == st_writeback) && writes_reg;
    assign ctrl.retire         = (state == st_writeback);
    assign output_valid        = (state == st_writeback) && is_wwd;
    assign is_halted           = (state == st_halted);

    ////////////////////
    // Checks

    a_one_strobe: assert property (@(posedge clk) disable iff (reset_n)
        !(read_m && write_m))
        else $error("read_m and write_m high together");

    a_req_hold: assert property (@(posedge clk) disable iff (reset_n)
        (read_m || write_m) && !mem_ready |=>
            $stable(read_m) && $stable(write_m) && $stable(use_alu_addr))
        else $error("memory request dropped before mem_ready");

    a_halt_quiet: assert property (@(posedge clk) disable iff (reset_n)
        state == st_halted |-> !read_m && !write_m)
        else $error("memory request while halted");

    a_wwd_known: assert property (@(posedge clk) disable iff (reset_n)
        output_valid |-> !$isunknown(rs_data))
        else $error("WWD outputs unknown register data");

endmodule

// File: source/pc_counter.sv
`timescale 1ns/1ns

module pc_counter
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    cpu_ctrl_if.pc               ctrl,
    output logic [word_size-1:0] pc,
    output logic [word_size-1:0] num_inst,
    output logic [word_size-1:0] link_value
);

    logic [word_size-1:0] pc_plus_one;

    assign pc_plus_one = pc + 1'b1;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
        end else if (ctrl.pc_load_jump) begin
            // Jump stays inside the current 4K page
            pc <= {pc[word_size-1:target_size], ctrl.jump_target};
        end else if (ctrl.pc_load_branch) begin
            pc <= pc_plus_one + ctrl.imm_ext;
        end else if (ctrl.pc_inc) begin
            pc <= pc_plus_one;
        end
    end

    // Return address captured before the jump replaces pc
    always_ff @(posedge clk) begin
        if (ctrl.pc_load_jump) begin
            link_value <= pc_plus_one;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst <= '0;
        end else if (ctrl.retire) begin
            num_inst <= num_inst + 1'b1;
        end
    end

    a_one_load: assert property (@(posedge clk) disable iff (reset_n)
        $onehot0({ctrl.pc_inc, ctrl.pc_load_branch, ctrl.pc_load_jump}))
        else $error("more than one PC update in a cycle");

endmodule

// File: source/register_file.sv
`timescale 1ns/1ns

module register_file
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    cpu_ctrl_if.regs             ctrl,
    input  logic [word_size-1:0] wr_data,
    output logic [word_size-1:0] rs_data,
    output logic [word_size-1:0] rt_data
);

    logic [word_size-1:0] regs [reg_count];

    ////////////////////
    // Write port

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write) begin
            regs[ctrl.wr_addr] <= wr_data;
        end
    end

    ////////////////////
    // Read ports

    // Asynchronous reads valid from decode onward
    assign rs_data = regs[ctrl.rs_addr];
    assign rt_data = regs[ctrl.rt_addr];

endmodule

// File: source/alu.sv
`timescale 1ns/1ns

module alu
    import cpu_pkg::*;
(
    cpu_ctrl_if.alu              ctrl,
    input  logic [word_size-1:0] a,
    input  logic [word_size-1:0] b,
    output logic [word_size-1:0] result,
    output logic                 zero
);

    logic [word_size-1:0] b_op;

    ////////////////////
    // Operand B

    always_comb begin
        if (!ctrl.alu_src_imm) begin
            b_op = b;
        end else if (ctrl.alu_op == alu_pass_b) begin
            // LHI puts the immediate in the high byte
            b_op = {ctrl.imm_ext[imm_size-1:0], {(word_size - imm_size){1'b0}}};
        end else begin
            b_op = ctrl.imm_ext;
        end
    end

    ////////////////////
    // Operation

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    result = a + b_op;
            alu_sub:    result = a - b_op;
            alu_and:    result = a & b_op;
            alu_or:     result = a | b_op;
            alu_pass_b: result = b_op;
            default:    result = a + b_op;
        endcase
    end

    // Branch compare works on the raw registers
    assign zero = (a == b);

endmodule

// File: source/cpu.sv
`timescale 1ns/1ns

module cpu
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    output logic                 read_m,
    output logic                 write_m,
    output logic [word_size-1:0] address,
    output logic [word_size-1:0] write_data,
    input  logic [word_size-1:0] read_data,
    input  logic                 mem_ready,
    output logic [word_size-1:0] output_port,
    output logic                 output_valid,
    output logic [word_size-1:0] num_inst,
    output logic                 is_halted
);

    logic [word_size-1:0] pc;
    logic [word_size-1:0] link_value;
    logic [word_size-1:0] rs_data;
    logic [word_size-1:0] rt_data;
    logic [word_size-1:0] alu_result;
    logic [word_size-1:0] load_data;
    logic [word_size-1:0] wr_data;
    logic                 zero;
    logic                 use_alu_addr;

    cpu_ctrl_if ctrl_bus ();

    ////////////////////
    // Blocks

    cpu_control control_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .ctrl         (ctrl_bus.ctrl),
        .rs_data      (rs_data),
        .zero         (zero),
        .read_data    (read_data),
        .mem_ready    (mem_ready),
        .read_m       (read_m),
        .write_m      (write_m),
        .use_alu_addr (use_alu_addr),
        .output_valid (output_valid),
        .is_halted    (is_halted)
    );

    pc_counter pc_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .ctrl       (ctrl_bus.pc),
        .pc         (pc),
        .num_inst   (num_inst),
        .link_value (link_value)
    );

    register_file regs_i (
        .clk     (clk),
        .reset_n (reset_n),
        .ctrl    (ctrl_bus.regs),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu alu_i (
        .ctrl   (ctrl_bus.alu),
        .a      (rs_data),
        .b      (rt_data),
        .result (alu_result),
        .zero   (zero)
    );

    ////////////////////
    // Memory and output

    assign address     = use_alu_addr ? alu_result : pc;
    assign write_data  = rt_data;
    assign output_port = rs_data;

    // Load data held until writeback
    always_ff @(posedge clk) begin
        if (use_alu_addr && read_m && mem_ready) begin
            load_data <= read_data;
        end
    end

    always_comb begin
        case (ctrl_bus.wr_sel)
            wr_sel_mem:  wr_data = load_data;
            wr_sel_link: wr_data = link_value;
            default:     wr_data = alu_result;
        endcase
    end

endmodule

// File: bench/cpu_checker.sv
`timescale 1ns/1ns

module cpu_checker
    import cpu_pkg::*;
(
    input logic                 clk,
    input logic                 reset_n,
    input logic                 read_m,
    input logic                 write_m,
    input logic [word_size-1:0] address,
    input logic [word_size-1:0] write_data,
    input logic                 mem_ready,
    input logic [word_size-1:0] output_port,
    input logic                 output_valid,
    input logic [word_size-1:0] num_inst,
    input logic                 is_halted
);

    logic [word_size-1:0] image [512];
    logic [word_size-1:0] exp_reads [$];
    logic [31:0]          exp_writes [$];
    logic [word_size-1:0] exp_outs [$];
    logic [word_size-1:0] want;
    logic [31:0]          want_write;
    logic [33:0]          req_now;
    logic [33:0]          prev_req;
    bit                   prev_wait = 1'b0;
    bit                   was_reset = 1'b0;
    bit                   active = 1'b0;
    string                test_name;
    int                   exp_count = 0;
    int                   test_errors = 0;
    int                   total_errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    task automatic show_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("** Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
    endtask

    ////////////////////
    // Instruction-set model run once per program

    task automatic start_test(input string name);
        logic [word_size-1:0] regs [reg_count];
        logic [word_size-1:0] dmem [512];
        logic [word_size-1:0] pc;
        logic [word_size-1:0] ir;
        logic [word_size-1:0] next_pc;
        logic [word_size-1:0] simm;
        logic [word_size-1:0] ea;
        int                   rs;
        int                   rt;
        int                   rd;
        bit                   done;
        test_name   = name;
        test_errors = 0;
        exp_count   = 0;
        exp_reads.delete();
        exp_writes.delete();
        exp_outs.delete();
        for (int a = 0; a < 512; a++) begin
            dmem[a] = image[a];
        end
        for (int r = 0; r < reg_count; r++) begin
            regs[r] = '0;
        end
        pc   = '0;
        done = 1'b0;
        while (!done && exp_count < 1000) begin
            ir = dmem[pc[8:0]];
            exp_reads.push_back(pc);
            exp_count++;
            rs      = ir[rs_msb:rs_lsb];
            rt      = ir[rt_msb:rt_lsb];
            rd      = ir[rd_msb:rd_lsb];
            simm    = {{8{ir[imm_msb]}}, ir[imm_msb:imm_lsb]};
            next_pc = pc + 16'd1;
            case (ir[op_msb:op_lsb])
                op_rtype: begin
                    case (ir[func_msb:func_lsb])
                        fn_add: regs[rd] = regs[rs] + regs[rt];
                        fn_sub: regs[rd] = regs[rs] - regs[rt];
                        fn_and: regs[rd] = regs[rs] & regs[rt];
                        fn_orr: regs[rd] = regs[rs] | regs[rt];
                        fn_wwd: exp_outs.push_back(regs[rs]);
                        fn_hlt: done = 1'b1;
                    endcase
                end
                op_adi: regs[rt] = regs[rs] + simm;
                op_lhi: regs[rt] = {ir[imm_msb:imm_lsb], 8'h00};
                op_lwd: begin
                    ea = regs[rs] + simm;
                    exp_reads.push_back(ea);
                    regs[rt] = dmem[ea[8:0]];
                end
                op_swd: begin
                    ea = regs[rs] + simm;
                    exp_writes.push_back({ea, regs[rt]});
                    dmem[ea[8:0]] = regs[rt];
                end
                op_bne: if (regs[rs] != regs[rt]) next_pc = pc + 16'd1 + simm;
                op_beq: if (regs[rs] == regs[rt]) next_pc = pc + 16'd1 + simm;
                op_jmp: next_pc = {pc[15:12], ir[target_msb:target_lsb]};
                op_jal: begin
                    regs[link_reg] = pc + 16'd1;
                    next_pc = {pc[15:12], ir[target_msb:target_lsb]};
                end
                default: done = 1'b1;
            endcase
            pc = next_pc;
        end
        active = 1'b1;
    endtask

    task automatic finish_test();
        active = 1'b0;
        if (is_halted !== 1'b1) begin
            note_failure("is_halted did not rise after HLT");
        end
        if (num_inst !== 16'(exp_count)) begin
            show_mismatch("num_inst", exp_count, num_inst);
        end
        if (exp_reads.size() != 0) begin
            note_failure($sformatf("%0d expected reads never came", exp_reads.size()));
        end
        if (exp_writes.size() != 0) begin
            note_failure($sformatf("%0d expected writes never came", exp_writes.size()));
        end
        if (exp_outs.size() != 0) begin
            note_failure($sformatf("%0d expected WWD outputs never came", exp_outs.size()));
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %s done: %0d instructions, %0d errors", test_name, exp_count, test_errors);
    endtask

    ////////////////////
    // Port monitor sampled mid-cycle

    always @(negedge clk) begin
        if (reset_n) begin
            was_reset = 1'b1;
            prev_wait = 1'b0;
        end else begin
            if (was_reset && active && ({read_m, write_m, output_valid, is_halted} !== 4'b0 ||
                                        num_inst !== '0)) begin
                note_failure("outputs not cleared by reset");
            end
            was_reset = 1'b0;
            if (active) begin
                req_now = {read_m, write_m, address, write_m ? write_data : 16'h0};
                if (prev_wait && req_now !== prev_req) begin
                    note_failure("memory request changed while waiting for mem_ready");
                end
                prev_wait = (read_m || write_m) && !mem_ready;
                prev_req  = req_now;
                if (read_m && mem_ready) begin
                    if (exp_reads.size() == 0) begin
                        note_failure($sformatf("unexpected read of address %h", address));
                    end else begin
                        want = exp_reads.pop_front();
                        if (address !== want) show_mismatch("read address", want, address);
                    end
                end
                if (write_m && mem_ready) begin
                    if (exp_writes.size() == 0) begin
                        note_failure($sformatf("unexpected write to address %h", address));
                    end else begin
                        want_write = exp_writes.pop_front();
                        if ({address, write_data} !== want_write) begin
                            show_mismatch("write address/data", want_write, {address, write_data});
                        end
                    end
                end
                if (output_valid) begin
                    if (exp_outs.size() == 0) begin
                        note_failure("unexpected output_valid pulse");
                    end else begin
                        want = exp_outs.pop_front();
                        if (output_port !== want) show_mismatch("output_port", want, output_port);
                    end
                end
                if (is_halted && (read_m || write_m)) begin
                    note_failure("memory request after halt");
                end
            end
        end
    end

endmodule

// File: bench/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb
    import cpu_pkg::*;
();

    localparam int mem_words   = 512;
    localparam int cycle_limit = 3 * 64 * 11 + 200;

    logic                 clk;
    logic                 reset_n;
    logic                 read_m;
    logic                 write_m;
    logic                 mem_ready;
    logic                 output_valid;
    logic                 is_halted;
    logic [word_size-1:0] address;
    logic [word_size-1:0] write_data;
    logic [word_size-1:0] read_data;
    logic [word_size-1:0] output_port;
    logic [word_size-1:0] num_inst;
    logic [word_size-1:0] mem [mem_words];
    integer               seed = 32'hd613_99b3;
    int                   cycles = 0;
    int                   wait_left = -1;

    cpu cpu_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .read_m       (read_m),
        .write_m      (write_m),
        .address      (address),
        .write_data   (write_data),
        .read_data    (read_data),
        .mem_ready    (mem_ready),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    cpu_checker checker_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .read_m       (read_m),
        .write_m      (write_m),
        .address      (address),
        .write_data   (write_data),
        .mem_ready    (mem_ready),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: programs did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////
    // Memory with random ready delay

    always begin
        @(posedge clk);
        #10;
        mem_ready = 1'b0;
        if (read_m || write_m) begin
            if (wait_left < 0) begin
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                if (write_m) begin
                    mem[address[8:0]] = write_data;
                end else begin
                    read_data = mem[address[8:0]];
                end
            end
            wait_left--;
        end
    end

    ////////////////////
    // Program generator

    function automatic logic [15:0] rtype(int rs, int rt, int rd, logic [5:0] fn);
        return {op_rtype, 2'(rs), 2'(rt), 2'(rd), fn};
    endfunction

    function automatic logic [15:0] itype(logic [3:0] op, int rs, int rt, logic [7:0] imm);
        return {op, 2'(rs), 2'(rt), imm};
    endfunction

    // Kind 0 is ALU work, 1 memory traffic, 2 control flow
    task automatic build_program(input int kind);
        int         n;
        int         pick;
        int         dst;
        int         src;
        int         oth;
        int         ahead;
        logic [7:0] imm;
        for (int a = 0; a < mem_words; a++) begin
            mem[a] = 16'(a * 16'h9e37) ^ 16'h5a5a;
        end
        n = 48 + $unsigned($random(seed)) % 17;
        // r3 holds the data base 0x0100
        mem[0] = itype(op_lhi, 0, 3, 8'h01);
        for (int i = 1; i < n - 1; i++) begin
            pick  = $unsigned($random(seed)) % 8;
            dst   = $unsigned($random(seed)) % 3;
            src   = $unsigned($random(seed)) % 4;
            oth   = $unsigned($random(seed)) % 4;
            ahead = $unsigned($random(seed)) % (n - 1 - i);
            imm   = 8'($random(seed));
            case (kind * 8 + pick)
                0:       mem[i] = rtype(src, oth, dst, fn_add);
                1:       mem[i] = rtype(src, oth, dst, fn_sub);
                2:       mem[i] = rtype(src, oth, dst, fn_and);
                3:       mem[i] = rtype(src, oth, dst, fn_orr);
                4, 12:   mem[i] = itype(op_adi, src, dst, imm);
                5:       mem[i] = itype(op_lhi, 0, dst, imm);
                8, 9:    mem[i] = itype(op_lwd, 3, dst, imm & 8'h7f);
                10, 11:  mem[i] = itype(op_swd, 3, src, imm & 8'h7f);
                13:      mem[i] = rtype(src, oth, dst, fn_add);
                16:      mem[i] = itype(op_beq, src, oth, 8'(ahead));
                17:      mem[i] = itype(op_bne, src, oth, 8'(ahead));
                18:      mem[i] = {op_jmp, 12'(i + 1 + ahead)};
                19:      mem[i] = {op_jal, 12'(i + 1 + ahead)};
                20, 21:  mem[i] = itype(op_adi, src, dst, imm & 8'h07);
                23:      mem[i] = rtype(link_reg, 0, 0, fn_wwd);
                default: mem[i] = rtype(src, 0, 0, fn_wwd);
            endcase
        end
        mem[n - 1] = rtype(0, 0, 0, fn_hlt);
        for (int a = 0; a < mem_words; a++) begin
            checker_i.image[a] = mem[a];
        end
    endtask

    task automatic run_test(input string name, input int kind);
        build_program(kind);
        checker_i.start_test(name);
        @(posedge clk);
        #10;
        reset_n = 1'b1;
        repeat (3) @(posedge clk);
        #10;
        reset_n = 1'b0;
        while (is_halted !== 1'b1) @(posedge clk);
        // A few quiet cycles to catch requests after halt
        repeat (4) @(posedge clk);
        checker_i.finish_test();
    endtask

    initial begin
        reset_n   = 1'b1;
        mem_ready = 1'b0;
        read_data = '0;
        run_test("alu_mix", 0);
        run_test("mem_mix", 1);
        run_test("branch_mix", 2);
        $display("Tests run %0d, failed %0d, errors %0d", checker_i.tests_run,
                 checker_i.tests_failed, checker_i.total_errors);
        if (checker_i.tests_failed == 0 && checker_i.tests_run == 3) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
source/cpu_pkg.sv
source/cpu_ctrl_if.sv
source/cpu_control.sv
source/pc_counter.sv
source/register_file.sv
source/alu.sv
source/cpu.sv
bench/cpu_checker.sv
bench/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - source/cpu_pkg.sv
  - source/cpu_ctrl_if.sv
  - source/cpu_control.sv
  - source/pc_counter.sv
  - source/register_file.sv
  - source/alu.sv
  - source/cpu.sv
  - target: test
    files:
      - bench/cpu_checker.sv
      - bench/cpu_tb.sv
